// File: rtl/top_pkg.sv
// clock divider and power sequencing constants
// counter types for the strobe, step and power step counters

package top_pkg;

   // ----------------------------------------
   // clock division
   // ----------------------------------------

   // clk_100 cycles per 400 kHz strobe
   localparam int NUM_CLK_FOR_400KHZ = 250;

   // strobes per power step, one second at 400 kHz
   localparam int NUM_STROBE_FOR_STEP = 400000;

   // ----------------------------------------
   // power sequence
   // ----------------------------------------

   // step count at which the sensor supply is switched on
   localparam int CAM_EN_STEP = 2;
   // step count at which the i2c side leaves reset
   localparam int I2C_RELEASE_STEP = 4;
   // step counter stops here, outputs are frozen after that
   localparam int STEP_CNT_MAX = 8;

   typedef logic [$clog2(NUM_CLK_FOR_400KHZ)-1:0]  cnt_400khz_t;
   typedef logic [$clog2(NUM_STROBE_FOR_STEP)-1:0] cnt_step_t;
   typedef logic [3:0]                             step_cnt_t;

endpackage : top_pkg

// File: rtl/i2c_pkg.sv
// i2c register write command and write result structs
// sensor init table and its index type

package i2c_pkg;

   // one sensor register write: address byte, 16-bit register, data byte
   typedef struct packed {
      logic [6:0]  dev_addr;
      logic [15:0] reg_addr;
      logic [7:0]  data;
   } i2c_wr_t;

   // outcome of one write
   typedef struct packed {
      // set when any byte was refused
      logic       nack;
      // 0 address, 1 reg high, 2 reg low, 3 data
      logic [1:0] byte_idx;
   } i2c_res_t;

   // 7-bit sensor address
   localparam logic [6:0] CAM_DEV_ADDR = 7'h10;

   localparam int INIT_LEN = 6;

   typedef logic [$clog2(INIT_LEN)-1:0] init_idx_t;

   // standby first, then pll setup, then raw10 output format
   localparam i2c_wr_t INIT_TABLE [INIT_LEN] = '{
      '{dev_addr: CAM_DEV_ADDR, reg_addr: 16'h0100, data: 8'h00},
      '{dev_addr: CAM_DEV_ADDR, reg_addr: 16'h0304, data: 8'h03},
      '{dev_addr: CAM_DEV_ADDR, reg_addr: 16'h0305, data: 8'h03},
      '{dev_addr: CAM_DEV_ADDR, reg_addr: 16'h0307, data: 8'h39},
      '{dev_addr: CAM_DEV_ADDR, reg_addr: 16'h018C, data: 8'h0A},
      '{dev_addr: CAM_DEV_ADDR, reg_addr: 16'h018D, data: 8'h0A}
   };

endpackage : i2c_pkg

// File: rtl/clkrst_gen.sv
// 400 kHz strobe for the i2c master
// slow step tick with a heartbeat toggling on every tick
// staged release of the sensor supply and of the i2c reset

module clkrst_gen #(
   parameter int NUM_CLK_FOR_400KHZ  = top_pkg::NUM_CLK_FOR_400KHZ,
   parameter int NUM_STROBE_FOR_STEP = top_pkg::NUM_STROBE_FOR_STEP
) (
   input  logic clk_100,
   input  logic reset,
   output logic strobe_400khz,
   output logic step_tick,
   output logic heartbeat,
   output logic cam_en,
   output logic i2c_reset
);
   import top_pkg::*;

   cnt_400khz_t cnt_400khz;
   cnt_step_t   cnt_step;
   step_cnt_t   step_cnt;

   // ----------------------------------------
   // strobe divider
   // ----------------------------------------

   // one-cycle pulse when the counter wraps
   always_ff @(posedge clk_100) begin
      if (reset) begin
         cnt_400khz    <= '0;
         strobe_400khz <= 1'b0;
      end else begin
         if (cnt_400khz == cnt_400khz_t'(NUM_CLK_FOR_400KHZ - 1)) begin
            cnt_400khz    <= '0;
            strobe_400khz <= 1'b1;
         end else begin
            cnt_400khz    <= cnt_400khz_t'(cnt_400khz + 1'b1);
            strobe_400khz <= 1'b0;
         end
      end
   end

   // ----------------------------------------
   // step tick and power sequence
   // ----------------------------------------

   always_ff @(posedge clk_100) begin
      if (reset) begin
         cnt_step  <= '0;
         step_tick <= 1'b0;
         heartbeat <= 1'b0;
         step_cnt  <= '0;
         cam_en    <= 1'b0;
         i2c_reset <= 1'b1;
      end else begin
         step_tick <= 1'b0;
         // counts strobes only
         if (strobe_400khz) begin
            if (cnt_step == cnt_step_t'(NUM_STROBE_FOR_STEP - 1)) begin
               cnt_step  <= '0;
               step_tick <= 1'b1;
               heartbeat <= ~heartbeat;
               // saturates, so both enables are frozen afterwards
               if (step_cnt < step_cnt_t'(STEP_CNT_MAX)) begin
                  step_cnt  <= step_cnt_t'(step_cnt + 1'b1);
                  // compares the count before this tick, so cam_en rises on tick 3
                  cam_en    <= (step_cnt >= step_cnt_t'(CAM_EN_STEP));
                  // i2c leaves reset on tick 5, sensor has had two steps of supply
                  i2c_reset <= (step_cnt < step_cnt_t'(I2C_RELEASE_STEP));
               end
            end else begin
               cnt_step <= cnt_step_t'(cnt_step + 1'b1);
            end
         end
      end
   end

endmodule : clkrst_gen

// File: rtl/i2c_master.sv
// write-only i2c master, one register write per command
// start, four bytes each with an ack bit, stop
// every bit is four strobe quarters, so scl runs at 100 kHz
// a refused byte cuts the write short with a stop

module i2c_master (
   input  logic              clk_100,
   input  logic              i2c_reset,
   input  logic              strobe_400khz,
   input  i2c_pkg::i2c_wr_t  cmd,
   input  logic              cmd_valid,
   input  logic              sda_in,
   output logic              cmd_ready,
   output i2c_pkg::i2c_res_t res,
   output logic              res_valid,
   output logic              scl_oe,
   output logic              sda_oe
);
   import i2c_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_START,
      ST_BIT,
      ST_ACK,
      ST_STOP
   } state_t;

   state_t      state;
   state_t      nxt_state;
   logic [1:0]  quarter;
   logic [1:0]  nxt_quarter;
   logic [2:0]  bit_cnt;
   logic [2:0]  nxt_bit_cnt;
   logic [1:0]  byte_idx;
   logic [1:0]  nxt_byte_idx;
   // all four bytes, msb goes out first
   logic [31:0] frame;
   logic [31:0] nxt_frame;
   logic [1:0]  sda_sync;
   logic        accept;

   // bus enables for one quarter, {scl_oe, sda_oe}, 1 pulls low
   function automatic logic [1:0] bus_drive(state_t st, logic [1:0] q, logic bit_val);
      case (st)
         // sda falls while scl is high, then scl falls
         ST_START: return {q[1], q != 2'd0};
         // scl low in first and last quarter, sda only moves then
         ST_BIT:   return {(q == 2'd0) || (q == 2'd3), ~bit_val};
         // target owns sda during the ack bit
         ST_ACK:   return {(q == 2'd0) || (q == 2'd3), 1'b0};
         // sda rises while scl is high
         ST_STOP:  return {q == 2'd0, q[1] == 1'b0};
         default:  return 2'b00;
      endcase
   endfunction

   assign cmd_ready = (state == ST_IDLE);
   assign accept    = cmd_valid && cmd_ready;

   // ----------------------------------------
   // next state, advances once per strobe
   // ----------------------------------------
   always_comb begin
      nxt_state    = state;
      nxt_quarter  = quarter;
      nxt_bit_cnt  = bit_cnt;
      nxt_byte_idx = byte_idx;
      nxt_frame    = frame;
      if (accept) begin
         nxt_state    = ST_START;
         nxt_quarter  = 2'd0;
         nxt_bit_cnt  = 3'd7;
         nxt_byte_idx = 2'd0;
         // write bit is 0 after the address
         nxt_frame    = {cmd.dev_addr, 1'b0, cmd.reg_addr, cmd.data};
      end else if (strobe_400khz && (state != ST_IDLE)) begin
         nxt_quarter = 2'(quarter + 2'd1);
         if (quarter == 2'd3) begin
            case (state)
               ST_START: nxt_state = ST_BIT;
               ST_BIT: begin
                  nxt_frame = {frame[30:0], 1'b0};
                  if (bit_cnt == 3'd0) begin
                     nxt_state = ST_ACK;
                  end else begin
                     nxt_bit_cnt = 3'(bit_cnt - 3'd1);
                  end
               end
               ST_ACK: begin
                  // early stop on a refused byte
                  if (res.nack || (byte_idx == 2'd3)) begin
                     nxt_state = ST_STOP;
                  end else begin
                     nxt_state    = ST_BIT;
                     nxt_bit_cnt  = 3'd7;
                     nxt_byte_idx = 2'(byte_idx + 2'd1);
                  end
               end
               default: nxt_state = ST_IDLE;
            endcase
         end
      end
   end

   // ----------------------------------------
   // registers
   // ----------------------------------------
   always_ff @(posedge clk_100) begin
      if (i2c_reset) begin
         state     <= ST_IDLE;
         quarter   <= 2'd0;
         bit_cnt   <= 3'd0;
         byte_idx  <= 2'd0;
         res       <= '0;
         res_valid <= 1'b0;
         scl_oe    <= 1'b0;
         sda_oe    <= 1'b0;
      end else begin
         state    <= nxt_state;
         quarter  <= nxt_quarter;
         bit_cnt  <= nxt_bit_cnt;
         byte_idx <= nxt_byte_idx;
         // registered enables, no decode glitch reaches the bus
         {scl_oe, sda_oe} <= bus_drive(nxt_state, nxt_quarter, nxt_frame[31]);
         // pulse once the stop condition is complete
         res_valid <= strobe_400khz && (state == ST_STOP) && (quarter == 2'd3);
         if (accept) begin
            res <= '0;
         end else if (strobe_400khz && (state == ST_ACK) && (quarter == 2'd1) && sda_sync[1]) begin
            // middle of scl high, a released line means nack
            res.nack     <= 1'b1;
            res.byte_idx <= byte_idx;
         end
      end
   end

   // shift data and input synchronizer
   always_ff @(posedge clk_100) begin
      frame    <= nxt_frame;
      sda_sync <= {sda_sync[0], sda_in};
   end

endmodule : i2c_master

// File: rtl/cam_init_seq.sv
// sensor init sequencer
// walks the init table and hands one write at a time to the i2c master
// stops for good on the first refused write

module cam_init_seq (
   input  logic              clk_100,
   input  logic              i2c_reset,
   input  logic              cmd_ready,
   input  i2c_pkg::i2c_res_t res,
   input  logic              res_valid,
   output i2c_pkg::i2c_wr_t  cmd,
   output logic              cmd_valid,
   output logic              init_done,
   output logic              init_error
);
   import i2c_pkg::*;

   // current table entry
   init_idx_t idx;
   // command accepted, result still outstanding
   logic      wait_res;

   // stays steady until the master takes it, idx only moves on a result
   assign cmd = INIT_TABLE[idx];

   // ----------------------------------------
   // issue and result tracking
   // ----------------------------------------
   always_ff @(posedge clk_100) begin
      if (i2c_reset) begin
         idx        <= '0;
         cmd_valid  <= 1'b0;
         wait_res   <= 1'b0;
         init_done  <= 1'b0;
         init_error <= 1'b0;
      end else begin
         // handshake with the master
         if (cmd_valid && cmd_ready) begin
            cmd_valid <= 1'b0;
            wait_res  <= 1'b1;
         end else if (!cmd_valid && !wait_res && !init_done && !init_error) begin
            // nothing pending, offer the next entry
            cmd_valid <= 1'b1;
         end

         // result comes back after the stop condition
         if (res_valid && wait_res) begin
            wait_res <= 1'b0;
            if (res.nack) begin
               // sticky, no further commands
               init_error <= 1'b1;
            end else if (idx == init_idx_t'(INIT_LEN - 1)) begin
               // last entry acknowledged
               init_done <= 1'b1;
            end else begin
               idx <= init_idx_t'(idx + 1'b1);
            end
         end
      end
   end

endmodule : cam_init_seq

// File: rtl/cam_ctrl_top.sv
// camera control top level
// clock and reset generator, init sequencer and i2c write master
// i2c bus as open-drain enables plus the sampled sda line

module cam_ctrl_top #(
   parameter int NUM_CLK_FOR_400KHZ  = top_pkg::NUM_CLK_FOR_400KHZ,
   parameter int NUM_STROBE_FOR_STEP = top_pkg::NUM_STROBE_FOR_STEP
) (
   input  logic clk_100,
   input  logic reset,
   input  logic sda_in,
   output logic scl_oe,
   output logic sda_oe,
   output logic cam_en,
   output logic heartbeat,
   output logic init_done,
   output logic init_error
);
   import i2c_pkg::*;

   logic     strobe_400khz;
   logic     i2c_reset;
   i2c_wr_t  cmd;
   logic     cmd_valid;
   logic     cmd_ready;
   i2c_res_t res;
   logic     res_valid;

   // ----------------------------------------
   // power sequence and strobe
   // ----------------------------------------
   clkrst_gen #(
      .NUM_CLK_FOR_400KHZ  (NUM_CLK_FOR_400KHZ),
      .NUM_STROBE_FOR_STEP (NUM_STROBE_FOR_STEP)
   ) u_clkrst_gen (
      .clk_100       (clk_100),
      .reset         (reset),
      .strobe_400khz (strobe_400khz),
      // heartbeat already marks each step
      .step_tick     (),
      .heartbeat     (heartbeat),
      .cam_en        (cam_en),
      .i2c_reset     (i2c_reset)
   );

   // table walker, held idle until i2c_reset drops
   cam_init_seq u_cam_init_seq (
      .clk_100    (clk_100),
      .i2c_reset  (i2c_reset),
      .cmd_ready  (cmd_ready),
      .res        (res),
      .res_valid  (res_valid),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .init_done  (init_done),
      .init_error (init_error)
   );

   // bus side
   i2c_master u_i2c_master (
      .clk_100       (clk_100),
      .i2c_reset     (i2c_reset),
      .strobe_400khz (strobe_400khz),
      .cmd           (cmd),
      .cmd_valid     (cmd_valid),
      .sda_in        (sda_in),
      .cmd_ready     (cmd_ready),
      .res           (res),
      .res_valid     (res_valid),
      .scl_oe        (scl_oe),
      .sda_oe        (sda_oe)
   );

endmodule : cam_ctrl_top

// File: tb/i2c_slave_model.sv
// i2c target model for the testbench
// decodes start, four bytes with ack bits and stop on the open-drain bus
// acknowledges every byte except the one picked by nack_at and nack_wr
// logs each completed write, counts start and stop conditions

module i2c_slave_model (
   input  logic              scl,
   input  logic              sda,
   // nack enables the refusal, byte_idx picks the byte
   input  i2c_pkg::i2c_res_t nack_at,
   // write to refuse, counted from 0 since the last clear
   input  int                nack_wr,
   output logic              sda_pull
);
   import i2c_pkg::*;

   i2c_wr_t     wr_log [$];
   int          start_cnt;
   int          stop_cnt;
   logic        active;
   logic        in_ack;
   int          bit_cnt;
   int          byte_cnt;
   logic [31:0] shreg;

   task automatic clear_log();
      wr_log.delete();
      start_cnt = 0;
      stop_cnt  = 0;
   endtask

   function automatic int logged_count();
      return wr_log.size();
   endfunction

   function automatic i2c_wr_t logged_write(int i);
      return wr_log[i];
   endfunction

   initial begin
      sda_pull = 1'b0;
      active   = 1'b0;
      in_ack   = 1'b0;
      clear_log();
   end

   // start, sda falls while scl is high
   always @(negedge sda) begin
      if (scl === 1'b1) begin
         start_cnt++;
         active   = 1'b1;
         in_ack   = 1'b0;
         bit_cnt  = 0;
         byte_cnt = 0;
         shreg    = '0;
      end
   end

   // stop, sda rises while scl is high
   always @(posedge sda) begin
      if (scl === 1'b1 && active) begin
         stop_cnt++;
         active = 1'b0;
         // all four bytes acked and the write bit is 0
         if (byte_cnt == 4 && shreg[24] == 1'b0) begin
            wr_log.push_back(i2c_wr_t'({shreg[31:25], shreg[23:0]}));
         end
      end
   end

   // ----------------------------------------
   // bit level
   // ----------------------------------------

   // data and ack are sampled on the rising scl edge
   always @(posedge scl) begin
      if (active) begin
         if (in_ack) begin
            if (sda == 1'b0) begin
               byte_cnt++;
            end
         end else if (bit_cnt < 8 && byte_cnt < 4) begin
            // the scl rise of the stop after byte four carries no data
            shreg = {shreg[30:0], sda};
            bit_cnt++;
         end
      end
   end

   // sda only moves while scl is low
   always @(negedge scl) begin
      if (active) begin
         if (in_ack) begin
            in_ack   = 1'b0;
            sda_pull = 1'b0;
            bit_cnt  = 0;
         end else if (bit_cnt == 8) begin
            in_ack   = 1'b1;
            sda_pull = !(nack_at.nack && (nack_wr == start_cnt - 1) &&
                         (byte_cnt == int'(nack_at.byte_idx)));
         end
      end
   end

endmodule : i2c_slave_model

// File: tb/tb_cam_ctrl.sv
// testbench for the camera control top level
// clock and reset, directed tests for reset state, power order,
// register writes, completion and a refused data byte
// compare tasks per result type and the closing report

module tb_cam_ctrl;
   import i2c_pkg::*;

   localparam int CLK_DIV       = 4;
   localparam int STEP_LEN      = 8;
   localparam int STEP_CYCLES   = CLK_DIV * STEP_LEN;
   // start, 36 bits and stop, four strobes each
   localparam int WRITE_CYCLES  = 38 * 4 * CLK_DIV;
   localparam int POWER_TIMEOUT = 8 * STEP_CYCLES;
   localparam int INIT_TIMEOUT  = POWER_TIMEOUT + INIT_LEN * (WRITE_CYCLES + 32);
   localparam int IDLE_CYCLES   = 2 * WRITE_CYCLES;

   logic     clk_100;
   logic     reset;
   logic     sda_in;
   logic     scl_oe;
   logic     sda_oe;
   logic     cam_en;
   logic     heartbeat;
   logic     init_done;
   logic     init_error;
   logic     sda_pull;
   i2c_res_t nack_at;
   int       nack_wr;
   int       mismatch_cnt;
   int       timeout_cnt;

   cam_ctrl_top #(
      .NUM_CLK_FOR_400KHZ  (CLK_DIV),
      .NUM_STROBE_FOR_STEP (STEP_LEN)
   ) u_dut (
      .clk_100    (clk_100),
      .reset      (reset),
      .sda_in     (sda_in),
      .scl_oe     (scl_oe),
      .sda_oe     (sda_oe),
      .cam_en     (cam_en),
      .heartbeat  (heartbeat),
      .init_done  (init_done),
      .init_error (init_error)
   );

   // scl is only ever driven by the master
   i2c_slave_model u_slave (
      .scl      (~scl_oe),
      .sda      (sda_in),
      .nack_at  (nack_at),
      .nack_wr  (nack_wr),
      .sda_pull (sda_pull)
   );

   initial begin
      clk_100 = 1'b0;
      forever #5 clk_100 = ~clk_100;
   end

   // wired-AND sda, low if either side pulls
   always @(posedge clk_100) begin
      #1;
      sda_in = ~(sda_oe | sda_pull);
   end

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_wr(input string name, input i2c_wr_t got, input i2c_wr_t exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s = dev %h reg %h data %h, expected dev %h reg %h data %h",
                  $time, name, got.dev_addr, got.reg_addr, got.data,
                  exp.dev_addr, exp.reg_addr, exp.data);
      end
   endtask

   task automatic check_res(input string name, input i2c_res_t got, input i2c_res_t exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s = nack %b byte %0d, expected nack %b byte %0d",
                  $time, name, got.nack, got.byte_idx, exp.nack, exp.byte_idx);
      end
   endtask

   // every status output and both bus enables inactive
   task automatic check_idle_outputs();
      check_bit("cam_en", cam_en, 1'b0);
      check_bit("init_done", init_done, 1'b0);
      check_bit("init_error", init_error, 1'b0);
      check_bit("scl_oe", scl_oe, 1'b0);
      check_bit("sda_oe", sda_oe, 1'b0);
   endtask

   // eight edges with reset high, released 1 after the last one
   task automatic apply_reset();
      reset = 1'b1;
      // sequencer and master follow one edge later through i2c_reset
      @(posedge clk_100);
      repeat (6) begin
         @(posedge clk_100);
         @(negedge clk_100);
         check_idle_outputs();
      end
      @(posedge clk_100);
      #1;
      reset = 1'b0;
   endtask

   // sensor address with the table's register and value
   function automatic i2c_wr_t expected_write(int i);
      return '{dev_addr: CAM_DEV_ADDR, reg_addr: INIT_TABLE[i].reg_addr,
               data: INIT_TABLE[i].data};
   endfunction

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic test_reset_state();
      apply_reset();
      @(negedge clk_100);
      check_idle_outputs();
   endtask

   task automatic test_power_order();
      int   cycles;
      int   toggles;
      int   last_toggle;
      logic hb_prev;
      cycles      = 0;
      toggles     = 0;
      last_toggle = 0;
      hb_prev     = heartbeat;
      while (toggles < 5 && cycles < POWER_TIMEOUT) begin
         @(negedge clk_100);
         cycles++;
         if (heartbeat !== hb_prev) begin
            toggles++;
            hb_prev = heartbeat;
            // one step tick per step length
            if (toggles >= 2) begin
               check_count("heartbeat period", cycles - last_toggle, STEP_CYCLES);
            end
            last_toggle = cycles;
         end
         check_bit("cam_en", cam_en, toggles >= 3);
         // bus quiet until the i2c side leaves reset
         check_bit("scl_oe", scl_oe, 1'b0);
         check_count("start conditions", u_slave.start_cnt, 0);
      end
      if (toggles < 5) begin
         timeout_cnt++;
         $display("Timeout at %0t: only %0d heartbeat toggles seen", $time, toggles);
      end
   endtask

   task automatic test_register_writes();
      int cycles;
      int i;
      cycles = 0;
      while (u_slave.logged_count() < INIT_LEN && cycles < INIT_TIMEOUT) begin
         @(negedge clk_100);
         cycles++;
      end
      if (u_slave.logged_count() < INIT_LEN) begin
         timeout_cnt++;
         $display("Timeout at %0t: only %0d register writes completed on the bus",
                  $time, u_slave.logged_count());
      end
      check_count("logged writes", u_slave.logged_count(), INIT_LEN);
      for (i = 0; i < INIT_LEN && i < u_slave.logged_count(); i++) begin
         check_wr($sformatf("write %0d", i), u_slave.logged_write(i), expected_write(i));
      end
   endtask

   task automatic test_completion();
      int cycles;
      cycles = 0;
      while (init_done !== 1'b1 && cycles < WRITE_CYCLES) begin
         @(negedge clk_100);
         cycles++;
      end
      if (init_done !== 1'b1) begin
         timeout_cnt++;
         $display("Timeout at %0t: init_done did not rise after the last write", $time);
      end
      // last stop already seen, last write acknowledged
      check_count("stop conditions", u_slave.stop_cnt, INIT_LEN);
      check_res("res", u_dut.res, '{nack: 1'b0, byte_idx: 2'd0});
      repeat (IDLE_CYCLES) begin
         @(negedge clk_100);
         check_bit("init_done", init_done, 1'b1);
         check_bit("init_error", init_error, 1'b0);
         check_bit("scl_oe", scl_oe, 1'b0);
         check_bit("sda_oe", sda_oe, 1'b0);
      end
      check_count("start conditions", u_slave.start_cnt, INIT_LEN);
      check_count("logged writes", u_slave.logged_count(), INIT_LEN);
   endtask

   task automatic test_nack();
      int cycles;
      int i;
      @(posedge clk_100);
      #1;
      // refuse the data byte of write 2
      nack_at = '{nack: 1'b1, byte_idx: 2'd3};
      nack_wr = 2;
      u_slave.clear_log();
      apply_reset();
      cycles = 0;
      while (init_error !== 1'b1 && cycles < INIT_TIMEOUT) begin
         @(negedge clk_100);
         cycles++;
         check_bit("init_done", init_done, 1'b0);
      end
      if (init_error !== 1'b1) begin
         timeout_cnt++;
         $display("Timeout at %0t: init_error did not rise after the refused byte", $time);
      end
      check_res("res", u_dut.res, '{nack: 1'b1, byte_idx: 2'd3});
      repeat (IDLE_CYCLES) begin
         @(negedge clk_100);
         check_bit("init_done", init_done, 1'b0);
         check_bit("init_error", init_error, 1'b1);
         check_bit("scl_oe", scl_oe, 1'b0);
      end
      // writes 0 and 1 complete, write 2 cut short, nothing after its stop
      check_count("logged writes", u_slave.logged_count(), 2);
      for (i = 0; i < 2 && i < u_slave.logged_count(); i++) begin
         check_wr($sformatf("write %0d", i), u_slave.logged_write(i), expected_write(i));
      end
      check_count("start conditions", u_slave.start_cnt, 3);
      check_count("stop conditions", u_slave.stop_cnt, 3);
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      reset        = 1'b1;
      sda_in       = 1'b1;
      nack_at      = '0;
      nack_wr      = 0;
      mismatch_cnt = 0;
      timeout_cnt  = 0;
      test_reset_state();
      test_power_order();
      test_register_writes();
      test_completion();
      test_nack();
      $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
      if (mismatch_cnt == 0 && timeout_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule : tb_cam_ctrl

// File: compile.f
rtl/top_pkg.sv
rtl/i2c_pkg.sv
rtl/clkrst_gen.sv
rtl/i2c_master.sv
rtl/cam_init_seq.sv
rtl/cam_ctrl_top.sv
tb/i2c_slave_model.sv
tb/tb_cam_ctrl.sv

// File: Bender.yml
package:
  name: cam_ctrl

sources:
  # packages first, the rtl uses their types in port lists
  - rtl/top_pkg.sv
  - rtl/i2c_pkg.sv
  - rtl/clkrst_gen.sv
  - rtl/i2c_master.sv
  - rtl/cam_init_seq.sv
  - rtl/cam_ctrl_top.sv
  - target: simulation
    files:
      - tb/i2c_slave_model.sv
      - tb/tb_cam_ctrl.sv
